// File: common/calc_pkg.sv
package calc_pkg;

    localparam int OPERAND_W = 16;  // Operand and result width

    // Unsigned operand or result word
    typedef logic [OPERAND_W-1:0] operand_t;

    // One-hot operator codes as they come from the keypad
    typedef enum logic [2:0] {
        op_add = 3'b001,
        op_sub = 3'b010,
        op_mul = 3'b100
    } calc_op_t;

    // Request sent to an arithmetic unit along with its start pulse
    typedef struct packed {
        operand_t a;    // First operand, multiplicand
        operand_t b;    // Second operand, multiplier
        logic     sub;  // Subtract select, add/sub unit only
    } arith_req_t;

    // Response from a unit, also the display word
    typedef struct packed {
        operand_t value;  // Result modulo 2^16
        logic     flag;   // Carry, borrow or product overflow
    } arith_rsp_t;

    // Scale factor applied to the operand on each new digit
    localparam operand_t DIGIT_BASE = operand_t'(10);

endpackage

// File: src/add_sub_unit.sv
`timescale 1ns/1ps

module add_sub_unit (
    input  logic                 clk,
    input  logic                 nRST,
    input  logic                 start,
    input  calc_pkg::arith_req_t req,
    output logic                 finish,
    output calc_pkg::arith_rsp_t rsp
);
    import calc_pkg::*;

    localparam int NIBBLES = OPERAND_W / 4;

    logic       running;
    logic [1:0] cnt;      // Nibbles done so far
    operand_t   a_q;      // Remaining nibbles of a
    operand_t   b_q;      // Remaining nibbles of b, inverted for subtract
    operand_t   sum_q;    // Sum nibbles shift in from the top
    logic       carry_q;
    logic       sub_q;
    logic [3:0] nib_a;
    logic [3:0] nib_b;
    logic       cin;
    logic [4:0] nib_sum;
    operand_t   b_in;

    assign b_in = req.b ^ {OPERAND_W{req.sub}};  // One's complement, +1 via carry in

    // The start cycle already handles nibble zero
    always_comb begin
        nib_a   = start ? req.a[3:0] : a_q[3:0];
        nib_b   = start ? b_in[3:0] : b_q[3:0];
        cin     = start ? req.sub : carry_q;
        nib_sum = {1'b0, nib_a} + {1'b0, nib_b} + {4'd0, cin};
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            running <= 1'b0;
            cnt     <= '0;
            finish  <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (start) begin
                running <= 1'b1;
                cnt     <= 2'd1;
            end else if (running) begin
                if (cnt == 2'(NIBBLES - 1)) begin
                    running <= 1'b0;
                    finish  <= 1'b1;
                end
                cnt <= cnt + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            a_q   <= req.a >> 4;
            b_q   <= b_in >> 4;
            sub_q <= req.sub;
        end else if (running) begin
            a_q <= a_q >> 4;
            b_q <= b_q >> 4;
        end
        if (start || running) begin
            sum_q   <= {nib_sum[3:0], sum_q[OPERAND_W-1:4]};
            carry_q <= nib_sum[4];
        end
    end

    always_comb begin
        rsp.value = sum_q;
        rsp.flag  = sub_q ? ~carry_q : carry_q;  // No carry out means borrow
    end

    a_no_restart: assert property (
        @(posedge clk) disable iff (!nRST) start |-> !running
    );

endmodule

// File: src/shift_add_mult.sv
`timescale 1ns/1ps

module shift_add_mult #(
    parameter int BITS_PER_CYCLE = 2
) (
    input  logic                 clk,
    input  logic                 nRST,
    input  logic                 start,
    input  calc_pkg::arith_req_t req,
    output logic                 finish,
    output calc_pkg::arith_rsp_t rsp
);
    import calc_pkg::*;

    localparam int STEPS = 16 / BITS_PER_CYCLE;   // Cycles per product
    localparam int CNT_W = $clog2(STEPS) + 1;

    logic             running;
    logic [CNT_W-1:0] cnt;
    logic [31:0]      acc_q;        // Full 32-bit product
    logic [31:0]      mcand_q;      // Multiplicand, shifted left each step
    operand_t         mplier_q;     // Multiplier, shifted right each step
    logic [31:0]      step_acc;
    logic [31:0]      step_mcand;
    operand_t         step_mplier;
    logic [31:0]      partial;

    generate
        if ((16 % BITS_PER_CYCLE) != 0) begin : g_bad_radix
            $error("BITS_PER_CYCLE must divide 16");
        end
    endgenerate

    // Partial products for this step, first step straight from the request
    always_comb begin
        step_acc    = start ? '0 : acc_q;
        step_mcand  = start ? {16'd0, req.a} : mcand_q;
        step_mplier = start ? req.b : mplier_q;
        partial     = '0;
        for (int k = 0; k < BITS_PER_CYCLE; k++) begin
            if (step_mplier[k]) begin
                partial = partial + (step_mcand << k);
            end
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            running <= 1'b0;
            cnt     <= '0;
            finish  <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (start) begin
                running <= 1'b1;
                cnt     <= CNT_W'(1);
            end else if (running) begin
                if (cnt == CNT_W'(STEPS - 1)) begin
                    running <= 1'b0;
                    finish  <= 1'b1;
                end
                cnt <= cnt + CNT_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start || running) begin
            acc_q    <= step_acc + partial;
            mcand_q  <= step_mcand << BITS_PER_CYCLE;
            mplier_q <= step_mplier >> BITS_PER_CYCLE;
        end
    end

    always_comb begin
        rsp.value = acc_q[15:0];
        rsp.flag  = |acc_q[31:16];  // Product did not fit in 16 bits
    end

    a_no_restart: assert property (
        @(posedge clk) disable iff (!nRST) start |-> !running
    );

endmodule

// File: calc_control/calc_control.sv
`timescale 1ns/1ps

module calc_control #(
    parameter int BITS_PER_CYCLE = 2
) (
    input  logic                 clk,
    input  logic                 nRST,

    // Keypad side
    input  logic [3:0]           keypad_input,    // Decimal digit, 10 to 15 ignored
    input  logic                 read_input,      // Digit strobe
    input  calc_pkg::calc_op_t   operator_input,  // One-hot operator code
    input  logic                 equal_input,     // Equal strobe
    output logic                 busy,            // Strobes are dropped while high
    output logic                 complete,        // One-cycle result pulse
    output calc_pkg::arith_rsp_t display_output,

    // Add/sub unit
    output logic                 add_start,
    output calc_pkg::arith_req_t add_req,
    input  logic                 add_finish,
    input  calc_pkg::arith_rsp_t add_rsp,

    // Multiplier, shared by digit scaling and multiply
    output logic                 mul_start,
    output calc_pkg::arith_req_t mul_req,
    input  logic                 mul_finish,
    input  calc_pkg::arith_rsp_t mul_rsp
);
    import calc_pkg::*;

    localparam int MUL_WAIT_MAX = 16 / BITS_PER_CYCLE + 2;  // Longest start to finish

    typedef enum logic [2:0] {
        st_op1    = 3'd0,  // Entering first operand
        st_op2    = 3'd1,  // Entering second operand
        st_scale  = 3'd2,  // Operand times ten on the multiplier
        st_exec   = 3'd3,  // Waiting on the selected unit
        st_result = 3'd4   // Result latched, complete pulse
    } state_t;

    state_t    state;
    logic      second_q;  // Scaling belongs to operand two
    calc_op_t  op_q;      // Latched operator
    operand_t  operand1;
    operand_t  operand2;
    logic [3:0] digit_q;  // Digit added after scaling
    logic      digit_ok;
    logic      op_ok;
    logic      entry;     // In one of the two entry states
    logic      exec_done;
    operand_t  entry_operand;

    assign digit_ok  = read_input && (keypad_input < 4'd10);
    assign op_ok     = operator_input inside {op_add, op_sub, op_mul};
    assign entry     = (state == st_op1) || (state == st_op2);
    assign exec_done = (op_q == op_mul) ? mul_finish : add_finish;
    assign busy      = !entry;

    assign entry_operand = (state == st_op2) ? operand2 : operand1;

    // Sequencing and control registers
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= st_op1;
            second_q       <= 1'b0;
            op_q           <= op_add;
            operand1       <= '0;
            operand2       <= '0;
            add_start      <= 1'b0;
            mul_start      <= 1'b0;
            complete       <= 1'b0;
            display_output <= '0;
        end else begin
            add_start <= 1'b0;  // Start and complete are single pulses
            mul_start <= 1'b0;
            complete  <= 1'b0;

            case (state)
                st_op1: begin
                    if (digit_ok) begin
                        mul_start <= 1'b1;
                        second_q  <= 1'b0;
                        state     <= st_scale;
                    end else if (op_ok) begin
                        op_q  <= operator_input;
                        state <= st_op2;
                    end
                end

                st_op2: begin
                    if (digit_ok) begin
                        mul_start <= 1'b1;
                        second_q  <= 1'b1;
                        state     <= st_scale;
                    end else if (equal_input) begin
                        if (op_q == op_mul) begin
                            mul_start <= 1'b1;
                        end else begin
                            add_start <= 1'b1;
                        end
                        state <= st_exec;
                    end
                end

                st_scale: begin
                    if (mul_finish) begin
                        // Product already wrapped, digit add wraps too
                        if (second_q) begin
                            operand2 <= mul_rsp.value + operand_t'(digit_q);
                            state    <= st_op2;
                        end else begin
                            operand1 <= mul_rsp.value + operand_t'(digit_q);
                            state    <= st_op1;
                        end
                    end
                end

                st_exec: begin
                    if (exec_done) begin
                        display_output <= (op_q == op_mul) ? mul_rsp : add_rsp;
                        complete       <= 1'b1;
                        state          <= st_result;
                    end
                end

                st_result: begin
                    operand1 <= '0;  // Fresh entry for the next calculation
                    operand2 <= '0;
                    state    <= st_op1;
                end

                default: begin
                    state <= st_op1;
                end
            endcase
        end
    end

    // Request words, loaded alongside the start pulses
    always_ff @(posedge clk) begin
        if (entry && digit_ok) begin
            mul_req.a   <= entry_operand;
            mul_req.b   <= DIGIT_BASE;
            mul_req.sub <= 1'b0;
            digit_q     <= keypad_input;
        end else if ((state == st_op2) && equal_input) begin
            mul_req.a   <= operand1;
            mul_req.b   <= operand2;
            mul_req.sub <= 1'b0;
            add_req.a   <= operand1;
            add_req.b   <= operand2;
            add_req.sub <= (op_q == op_sub);
        end
    end

    // Only one unit may be started in a cycle
    a_single_start: assert property (
        @(posedge clk) disable iff (!nRST) !(add_start && mul_start)
    );

    a_complete_pulse: assert property (
        @(posedge clk) disable iff (!nRST) complete |=> !complete
    );

    // Scaling and multiply both rely on a bounded multiplier
    a_mul_wait: assert property (
        @(posedge clk) disable iff (!nRST) mul_start |-> ##[1:MUL_WAIT_MAX] mul_finish
    );

endmodule

// File: src/calc_top.sv
`timescale 1ns/1ps

module calc_top #(
    parameter int BITS_PER_CYCLE = 2
) (
    input  logic                 clk,
    input  logic                 nRST,
    input  logic [3:0]           keypad_input,
    input  logic                 read_input,
    input  calc_pkg::calc_op_t   operator_input,
    input  logic                 equal_input,
    output logic                 busy,
    output logic                 complete,
    output calc_pkg::arith_rsp_t display_output
);
    import calc_pkg::*;

    logic       add_start;
    logic       add_finish;
    arith_req_t add_req;
    arith_rsp_t add_rsp;
    logic       mul_start;
    logic       mul_finish;
    arith_req_t mul_req;
    arith_rsp_t mul_rsp;

    calc_control #(
        .BITS_PER_CYCLE(BITS_PER_CYCLE)
    ) control_u (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .busy           (busy),
        .complete       (complete),
        .display_output (display_output),
        .add_start      (add_start),
        .add_req        (add_req),
        .add_finish     (add_finish),
        .add_rsp        (add_rsp),
        .mul_start      (mul_start),
        .mul_req        (mul_req),
        .mul_finish     (mul_finish),
        .mul_rsp        (mul_rsp)
    );

    add_sub_unit add_u (
        .clk    (clk),
        .nRST   (nRST),
        .start  (add_start),
        .req    (add_req),
        .finish (add_finish),
        .rsp    (add_rsp)
    );

    shift_add_mult #(
        .BITS_PER_CYCLE(BITS_PER_CYCLE)
    ) mul_u (
        .clk    (clk),
        .nRST   (nRST),
        .start  (mul_start),
        .req    (mul_req),
        .finish (mul_finish),
        .rsp    (mul_rsp)
    );

endmodule

// File: test/calc_tb.sv
`timescale 1ns/1ps

module calc_tb;
    import calc_pkg::*;

    localparam int NUM_VEC    = 36;
    localparam int TIMEOUT_NS = (NUM_VEC * 200 + 16) * 40;  // 200 cycles per vector

    typedef struct packed {
        logic [31:0] typed_a;   // Decimal value as typed, may exceed 16 bits
        calc_op_t    op;
        logic [31:0] typed_b;
        arith_rsp_t  expected;
    } vector_t;

    logic       clk;
    logic       nRST;
    logic [3:0] keypad_input;
    logic       read_input;
    calc_op_t   operator_input;
    logic       equal_input;
    logic       busy;
    logic       complete;
    arith_rsp_t display_output;

    logic [31:0] golden_mem [0:NUM_VEC*5-1];  // Five words per vector
    logic [2:0]  bad_codes [4] = '{3'b011, 3'b101, 3'b110, 3'b111};
    integer      seed = 32'h14c497c6;
    int          error_count = 0;
    int          complete_count = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    logic        complete_last = 1'b0;
    arith_rsp_t  held_display = '0;

    calc_top #(
        .BITS_PER_CYCLE(2)
    ) uut (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .busy           (busy),
        .complete       (complete),
        .display_output (display_output)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns, the calculator stopped responding", TIMEOUT_NS);
        $display("Result: FAILED");
        $finish;
    end

    // Display may only move in a complete cycle, complete is a single pulse
    always @(negedge clk) begin
        if (nRST) begin
            if (complete) begin
                complete_count++;
                if (complete_last) begin
                    $display("complete stayed high for more than one cycle");
                    error_count++;
                end
            end else if (display_output !== held_display) begin
                $display("mismatch display_output: changed to %h without complete, held %h",
                         display_output, held_display);
                error_count++;
            end
            held_display  = display_output;
            complete_last = complete;
        end
    end

    function automatic int pick_below(input int n);
        return {$random(seed)} % n;
    endfunction

    // Result by the wrap and flag rules, from the operands as entered
    function automatic arith_rsp_t reference_result(input operand_t a, input calc_op_t op,
                                                    input operand_t b);
        logic [16:0] sum;
        logic [31:0] product;
        arith_rsp_t  r;
        sum     = {1'b0, a} + {1'b0, b};
        product = a * b;
        r       = '0;
        case (op)
            op_add: begin
                r.value = sum[15:0];
                r.flag  = sum[16];      // Carry out
            end
            op_sub: begin
                r.value = a - b;
                r.flag  = (b > a);      // Negative result
            end
            op_mul: begin
                r.value = product[15:0];
                r.flag  = |product[31:16];
            end
            default: begin
                r = '0;
            end
        endcase
        return r;
    endfunction

    task automatic next_cycle;
        @(posedge clk);
        #2;
    endtask

    task automatic compare_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("mismatch %s: got %h expected %h", name, actual, expected);
            error_count++;
        end
    endtask

    task automatic compare_rsp(input arith_rsp_t actual, input arith_rsp_t expected);
        if (actual.value !== expected.value) begin
            $display("mismatch display_output.value: got %h expected %h",
                     actual.value, expected.value);
            error_count++;
        end
        if (actual.flag !== expected.flag) begin
            $display("mismatch display_output.flag: got %h expected %h",
                     actual.flag, expected.flag);
            error_count++;
        end
    endtask

    task automatic wait_idle;
        int n;
        n = 0;
        while (busy && n < 100) begin
            next_cycle();
            n++;
        end
        if (busy) begin
            $display("busy stayed high for 100 cycles");
            error_count++;
        end
    endtask

    task automatic strobe_digit(input logic [3:0] code);
        keypad_input = code;
        read_input   = 1'b1;
        next_cycle();
        read_input   = 1'b0;
    endtask

    task automatic strobe_operator(input calc_op_t code);
        operator_input = code;
        next_cycle();
        operator_input = calc_op_t'(3'b000);  // Idle code, not one-hot
    endtask

    task automatic strobe_equal;
        equal_input = 1'b1;
        next_cycle();
        equal_input = 1'b0;
    endtask

    // Types the decimal digits, MSD first, and tracks the wrapped operand
    task automatic type_operand(input logic [31:0] typed, output operand_t entered);
        logic [3:0]  digits[$];
        logic [31:0] rest;
        rest    = typed;
        entered = '0;
        do begin
            digits.push_front(4'(rest % 10));
            rest = rest / 10;
        end while (rest != 0);
        foreach (digits[i]) begin
            repeat (pick_below(6)) next_cycle();
            wait_idle();
            if (pick_below(4) == 0) strobe_digit(4'(10 + pick_below(6)));  // Not a digit
            strobe_digit(digits[i]);
            compare_bit("busy", busy, 1'b1);
            if (pick_below(3) == 0) strobe_digit(4'(pick_below(10)));  // Dropped, busy
            entered = operand_t'(entered * 10 + digits[i]);
        end
    endtask

    task automatic run_vector(input int idx, input vector_t v);
        operand_t a_entered;
        operand_t b_entered;
        int       errors_before;
        int       completes_before;
        int       n;
        errors_before    = error_count;
        completes_before = complete_count;
        wait_idle();
        if (pick_below(3) == 0) strobe_equal();  // No operator yet
        type_operand(v.typed_a, a_entered);
        wait_idle();
        if (pick_below(3) == 0) strobe_operator(calc_op_t'(bad_codes[pick_below(4)]));
        strobe_operator(v.op);
        if (pick_below(3) == 0) strobe_operator(op_mul);  // Second operand phase
        type_operand(v.typed_b, b_entered);
        wait_idle();
        strobe_equal();
        compare_bit("busy", busy, 1'b1);
        if (pick_below(2) == 0) strobe_digit(4'd1);
        n = 0;
        while (!complete && n < 40) begin
            next_cycle();
            n++;
        end
        if (!complete) begin
            $display("complete did not pulse within 40 cycles of the equal strobe");
            error_count++;
        end
        compare_rsp(display_output, v.expected);
        if (reference_result(a_entered, v.op, b_entered) !== v.expected) begin
            $display("golden vector %0d disagrees with its typed operands and the wrap rules",
                     idx);
            error_count++;
        end
        next_cycle();
        compare_bit("complete", complete, 1'b0);
        if (complete_count != completes_before + 1) begin
            $display("expected one complete pulse, saw %0d", complete_count - completes_before);
            error_count++;
        end
        if (error_count == errors_before) pass_count++;
        else fail_count++;
        $display("test %0d: %0d op %b %0d -> %h flag %b, %s", idx, a_entered, v.op, b_entered,
                 display_output.value, display_output.flag,
                 (error_count == errors_before) ? "ok" : "error");
    endtask

    initial begin
        vector_t v;
        nRST           = 1'b0;
        keypad_input   = 4'd0;
        read_input     = 1'b0;
        operator_input = calc_op_t'(3'b000);
        equal_input    = 1'b0;
        $readmemh("test/calc_golden.txt", golden_mem);
        repeat (8) @(posedge clk);
        #2;
        nRST = 1'b1;

        compare_bit("busy", busy, 1'b0);
        compare_bit("complete", complete, 1'b0);
        compare_rsp(display_output, '0);
        if (error_count == 0) pass_count++;
        else fail_count++;
        $display("test 0: reset state, %s", (error_count == 0) ? "ok" : "error");

        if (^golden_mem[NUM_VEC*5-1] === 1'bx) begin
            $display("golden file is missing or holds fewer than %0d vectors", NUM_VEC);
            error_count++;
        end else begin
            for (int i = 0; i < NUM_VEC; i++) begin
                v.typed_a        = golden_mem[5*i];
                v.op             = calc_op_t'(golden_mem[5*i+1][2:0]);
                v.typed_b        = golden_mem[5*i+2];
                v.expected.value = golden_mem[5*i+3][15:0];
                v.expected.flag  = golden_mem[5*i+4][0];
                run_vector(i + 1, v);
            end
        end

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: test/calc_golden.txt
// operand one (decimal value as typed, hex) | operator (1 add, 2 sub, 4 mul)
// operand two (as typed, hex) | expected value | expected flag
0000000C 1 00000022 002E 0
00000000 1 00000000 0000 0
0000FFFF 1 00000001 0000 1
00009C40 1 00007530 1170 1
0000FFFF 1 0000FFFF FFFE 1
00003039 1 0000D431 046A 1
000003E7 1 00000001 03E8 0
00000064 2 0000003A 002A 0
00000005 2 00000007 FFFE 1
00000000 2 00000001 FFFF 1
000003E8 2 000003E8 0000 0
0000FFFF 2 00000000 FFFF 0
0000012C 2 0000FDE8 0344 1
0000C350 2 00003039 9317 0
00000006 4 00000007 002A 0
00000000 4 00003039 0000 0
000000FF 4 00000101 FFFF 0
00000100 4 00000100 0000 1
000003E8 4 000003E8 4240 1
0000FFFF 4 0000FFFF 0001 1
0000007B 4 0000002D 159F 0
0000012C 4 0000012C 5F90 1
00000009 4 00000001 0009 0
0001E240 1 00000001 E241 0
000186A0 2 00000001 869F 0
00000002 4 00010000 0000 0
05F5E0FF 1 00000000 E0FF 0
00011170 4 00000002 22E0 0
00000001 1 00000001 0002 0
00008000 1 00008000 0000 1
00001000 4 00000010 0000 1
00000FFF 4 00000010 FFF0 0
00000001 2 00000002 FFFF 1
0000270F 1 0000270F 4E1E 0
0001FFFF 2 00010001 FFFE 0
0000004D 4 00000353 FFF7 0

// File: calc_top.f
common/calc_pkg.sv
src/add_sub_unit.sv
src/shift_add_mult.sv
calc_control/calc_control.sv
src/calc_top.sv
test/calc_tb.sv
